// ==== all.f ====
cpu_pkg.sv
instr_if.sv
ifu.sv
instr_queue.sv
exec_unit.sv
cpu_top.sv
cpu_props.sv
tb_cpu.sv

// ==== Makefile ====
# Verilator build and run of the CPU testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cpu
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb_cpu.sv ====
/*
 * CPU testbench
 * random program checked against an ISA model, instruction and
 * data memory responders with random latency, store and redirect checks
 */

`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

localparam int CLK_NS = 8;
localparam int RST_CYCLES = 8;
localparam int PROG_WORDS = 64;
localparam int RUN_NS = PROG_WORDS * 20 * CLK_NS + RST_CYCLES * CLK_NS;
// a request this far out means every program word has been popped
localparam addr_t END_ADDR = PROG_WORDS * 4 + 4 * (4 + 2);

logic       clk = 1'b0;
logic       nrst;
word_t      i_IData;
logic       i_IRdy;
logic       i_DRdy;
addr_t      o_IAddr;
logic       o_IRdC;
addr_t      o_DAddr;
logic       o_DCmd;
logic       o_DRnW;
logic [3:0] o_DBen;
word_t      o_DData;

integer seed = 26539;
int     errors = 0;
int     failed = 0;
// responder latency limits and state
int     i_max;
int     d_max;
int     i_wait;
int     d_wait;
logic   i_busy;
logic   d_busy;

word_t  prog [PROG_WORDS];
// model results
addr_t  exp_addr [$];
word_t  exp_data [$];
addr_t  exp_tgt [$];
// progress through them
int     st_idx;
int     tgt_idx;
addr_t  req_addr [$];
logic   in_req;
logic   redir_pend;

cpu_top #(
	.RESET_ADDR(32'h0),
	.QUEUE_DEPTH(4)
) dut0 (.*);

always #(CLK_NS / 2) clk = ~clk;

// watchdog
initial
begin
	#(3 * RUN_NS);
	$display("timeout: the program did not finish within %0d ns", 3 * RUN_NS);
	$display("Done: errors found");
	$finish;
end

function automatic word_t fetch_word(input addr_t a);
	if (a < PROG_WORDS * 4)
		return prog[a >> 2];
	return '0;
endfunction

task automatic compare_hex(input string name, input word_t got, input word_t exp);
	assert (got == exp)
	else
	begin
		$display("Mismatch %s: got %h, expected %h", name, got, exp);
		errors++;
	end
endtask

// both memories driven on the falling edge
always @(negedge clk)
begin
	i_IRdy = 1'b0;
	i_DRdy = 1'b0;
	if (!o_IRdC)
		i_busy = 1'b0;
	else
	begin
		// new read gets a random latency
		if (!i_busy)
		begin
			i_busy = 1'b1;
			i_wait = {$random(seed)} % (i_max + 1);
		end
		if (i_wait == 0)
		begin
			i_IRdy = 1'b1;
			i_IData = fetch_word(o_IAddr);
			i_busy = 1'b0;
		end
		else
			i_wait--;
	end
	if (!o_DCmd)
		d_busy = 1'b0;
	else
	begin
		if (!d_busy)
		begin
			d_busy = 1'b1;
			d_wait = {$random(seed)} % (d_max + 1);
		end
		if (d_wait == 0)
		begin
			i_DRdy = 1'b1;
			d_busy = 1'b0;
		end
		else
			d_wait--;
	end
end

// fetch requests, redirects and completed stores
always @(posedge clk)
begin
	if (!nrst)
	begin
		in_req = 1'b0;
		redir_pend = 1'b0;
	end
	else
	begin
		// first cycle of a read
		if (o_IRdC && !in_req)
		begin
			req_addr.push_back(o_IAddr);
			if (redir_pend)
			begin
				compare_hex("o_IAddr", o_IAddr, exp_tgt[tgt_idx]);
				tgt_idx++;
				redir_pend = 1'b0;
			end
		end
		in_req = o_IRdC && !i_IRdy;
		// after a taken branch the next new read must go to the target
		if (dut0.iq.flush)
		begin
			assert (tgt_idx < exp_tgt.size())
			else
			begin
				$display("taken branch that the model does not take");
				errors++;
			end
			redir_pend = (tgt_idx < exp_tgt.size());
		end
		if (o_DCmd && i_DRdy)
		begin
			assert (st_idx < exp_addr.size())
			else
			begin
				$display("extra store beyond the %0d of the model", exp_addr.size());
				errors++;
			end
			if (st_idx < exp_addr.size())
			begin
				compare_hex("o_DAddr", o_DAddr, exp_addr[st_idx]);
				compare_hex("o_DData", o_DData, exp_data[st_idx]);
				compare_hex("o_DBen", {28'd0, o_DBen}, 32'hf);
				compare_hex("o_DRnW", {31'd0, o_DRnW}, 32'h0);
			end
			st_idx++;
		end
	end
end

// registers 1 to 7 first get known values and then a random mix
task automatic make_program();
	word_t  rnd;
	int     kind;
	regno_t s;
	regno_t t;
	regno_t d;
	for (int k = 0; k < PROG_WORDS; k++)
	begin
		rnd = $random(seed);
		s = {2'b00, rnd[31:29]};
		t = {2'b00, rnd[28:26]};
		d = {2'b00, rnd[25:23]};
		kind = (k < 7) ? 10 : {$random(seed)} % 10;
		case (kind)
		0: prog[k] = {OP_SPECIAL, s, t, d, 5'd0, FN_ADDU};
		1: prog[k] = {OP_SPECIAL, s, t, d, 5'd0, FN_SUBU};
		2: prog[k] = {OP_SPECIAL, s, t, d, 5'd0, FN_AND};
		3: prog[k] = {OP_SPECIAL, s, t, d, 5'd0, FN_OR};
		4: prog[k] = {OP_SPECIAL, s, t, d, 5'd0, FN_XOR};
		5: prog[k] = {OP_ADDIU, s, t, rnd[15:0]};
		// forward only by 0 to 3 words
		6: prog[k] = {OP_BEQ, s, t, 14'd0, rnd[1:0]};
		7: prog[k] = {OP_BNE, s, t, 14'd0, rnd[1:0]};
		8: prog[k] = {OP_SW, s, t, {10{rnd[5]}}, rnd[5:0]};
		// preamble loads
		10: prog[k] = {OP_ADDIU, 5'd0, 5'(k + 1), rnd[15:0]};
		// lui is not kept and runs as a nop
		default: prog[k] = {6'h0f, rnd[25:0]};
		endcase
	end
endtask

// ISA reference without delay slot where r0 reads zero
task automatic run_model();
	word_t r [32];
	addr_t pc;
	word_t w;
	word_t a;
	word_t b;
	word_t imm;
	exp_addr.delete();
	exp_data.delete();
	exp_tgt.delete();
	for (int k = 0; k < 32; k++)
		r[k] = '0;
	pc = '0;
	while (pc < PROG_WORDS * 4)
	begin
		w = prog[pc >> 2];
		a = r[w[25:21]];
		b = r[w[20:16]];
		imm = {{16{w[15]}}, w[15:0]};
		pc = pc + 4;
		case (w[31:26])
		OP_SPECIAL:
			case (w[5:0])
			FN_ADDU: r[w[15:11]] = a + b;
			FN_SUBU: r[w[15:11]] = a - b;
			FN_AND:  r[w[15:11]] = a & b;
			FN_OR:   r[w[15:11]] = a | b;
			FN_XOR:  r[w[15:11]] = a ^ b;
			default: ;
			endcase
		OP_ADDIU: r[w[20:16]] = a + imm;
		OP_BEQ, OP_BNE:
			if ((a == b) == (w[31:26] == OP_BEQ))
			begin
				pc = pc + (imm << 2);
				exp_tgt.push_back(pc);
			end
		OP_SW:
		begin
			exp_addr.push_back(a + imm);
			exp_data.push_back(b);
		end
		default: ;
		endcase
		r[0] = '0;
	end
endtask

task automatic apply_reset();
	@(negedge clk);
	nrst = 1'b0;
	repeat (RST_CYCLES)
	begin
		@(negedge clk);
		assert (!o_IRdC && !o_DCmd)
		else
		begin
			$display("o_IRdC or o_DCmd is high during reset");
			errors++;
		end
	end
	nrst = 1'b1;
endtask

// one full pass of the program under the given latency limits
task automatic run_program(input string name, input int imax, input int dmax);
	int base;
	base = errors;
	i_max = imax;
	d_max = dmax;
	st_idx = 0;
	tgt_idx = 0;
	req_addr.delete();
	apply_reset();
	while (!(req_addr.size() > 0 && req_addr[$] >= END_ADDR && !o_DCmd))
		@(negedge clk);
	compare_hex("o_IAddr", req_addr[0], 32'h0);
	compare_hex("o_IAddr", req_addr[1], INSTR_SIZE);
	assert (st_idx == exp_addr.size())
	else
	begin
		$display("%0d stores seen but the model made %0d", st_idx, exp_addr.size());
		errors++;
	end
	assert (tgt_idx == exp_tgt.size())
	else
	begin
		$display("%0d redirects seen but the model took %0d", tgt_idx, exp_tgt.size());
		errors++;
	end
	if (errors == base)
		$display("test %s: ok, %0d stores", name, st_idx);
	else
	begin
		failed++;
		$display("test %s: %0d errors", name, errors - base);
	end
endtask

initial
begin
	nrst = 1'b0;
	i_IData = '0;
	i_IRdy = 1'b0;
	i_DRdy = 1'b0;
	i_max = 0;
	d_max = 0;
	i_busy = 1'b0;
	d_busy = 1'b0;
	in_req = 1'b0;
	redir_pend = 1'b0;
	make_program();
	run_model();
	run_program("no wait states", 0, 0);
	run_program("random wait states", 3, 5);
	// queue fills and drains under long stalls
	run_program("long wait states", 7, 11);
	$display("tests run: 3, failed: %0d, errors: %0d", failed, errors);
	if (errors == 0)
		$display("Done: no errors");
	else
		$display("Done: errors found");
	$finish;
end

endmodule

// ==== cpu_props.sv ====
/*
 * CPU port protocol checks
 * bound into cpu_top, instruction and data handshakes and reset state
 */

`timescale 1ns/1ps

module cpu_props import cpu_pkg::*; (
	input logic  clk,
	input logic  nrst,
	input addr_t o_IAddr,
	input logic  o_IRdC,
	input logic  i_IRdy,
	input addr_t o_DAddr,
	input logic  o_DCmd,
	input logic  o_DRnW,
	input word_t o_DData,
	input logic  i_DRdy
);

// read held with its address until ready
iaddr_stable: assert property (@(posedge clk) disable iff (!nrst)
	o_IRdC && !i_IRdy |=> o_IRdC && $stable(o_IAddr))
	else $error("instruction read dropped or moved before i_IRdy");

// store held with address and data until ready
dcmd_stable: assert property (@(posedge clk) disable iff (!nrst)
	o_DCmd && !i_DRdy |=> o_DCmd && $stable(o_DAddr) && $stable(o_DData))
	else $error("store dropped or changed before i_DRdy");

// stores only
drnw_low: assert property (@(posedge clk) disable iff (!nrst) o_DCmd |-> !o_DRnW)
	else $error("o_DRnW high with o_DCmd");

reset_quiet: assert property (@(posedge clk) !nrst |-> !o_IRdC && !o_DCmd)
	else $error("bus command active during reset");

endmodule

bind cpu_top cpu_props props0 (.*);

// ==== cpu_top.sv ====
/*
 * CPU top level
 * connects fetch unit, instruction queue and execute unit,
 * exposes the instruction and data ports
 */

`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter addr_t RESET_ADDR  = '0,
	parameter int    QUEUE_DEPTH = 4
) (
	input  logic       clk,
	input  logic       nrst,
	// instruction port
	output addr_t      o_IAddr,
	output logic       o_IRdC,
	input  word_t      i_IData,
	input  logic       i_IRdy,
	// data port
	output addr_t      o_DAddr,
	output logic       o_DCmd,
	output logic       o_DRnW,
	output logic [3:0] o_DBen,
	output word_t      o_DData,
	input  logic       i_DRdy
);

// instruction stream between the units
instr_if iq ();

// fetch
ifu #(
	.RESET_ADDR(RESET_ADDR)
) ifu0 (
	.clk(clk),
	.nrst(nrst),
	.i_IData(i_IData),
	.i_IRdy(i_IRdy),
	.o_IAddr(o_IAddr),
	.o_IRdC(o_IRdC),
	.fq(iq.fetch)
);

// buffer
instr_queue #(
	.QUEUE_DEPTH(QUEUE_DEPTH)
) queue0 (
	.clk(clk),
	.nrst(nrst),
	.q(iq.queue)
);

// execute and store
exec_unit exec0 (
	.clk(clk),
	.nrst(nrst),
	.eq(iq.exec),
	.o_DAddr(o_DAddr),
	.o_DCmd(o_DCmd),
	.o_DRnW(o_DRnW),
	.o_DBen(o_DBen),
	.o_DData(o_DData),
	.i_DRdy(i_DRdy)
);

endmodule

// ==== exec_unit.sv ====
/*
 * Execute unit
 * decodes the popped instruction, reads and writes the register file,
 * computes ALU results, resolves branches and issues word stores
 */

`timescale 1ns/1ps

module exec_unit import cpu_pkg::*; (
	input  logic       clk,
	input  logic       nrst,
	instr_if.exec      eq,
	output addr_t      o_DAddr,
	output logic       o_DCmd,
	output logic       o_DRnW,
	output logic [3:0] o_DBen,
	output word_t      o_DData,
	input  logic       i_DRdy
);

ex_state_t state;

// register file, entry 0 never written
word_t regs [32];

// instruction fields
logic [5:0] op;
logic [5:0] fn;
regno_t     rs;
regno_t     rt;
regno_t     rd;
word_t      simm;

word_t rs_val;
word_t rt_val;

// decode results
logic   fire;
logic   wr_en;
regno_t wr_reg;
word_t  wr_val;
logic   taken;
logic   is_sw;

// payload of the pending store
addr_t st_addr;
word_t st_data;

assign op = eq.pop_instr[31:26];
assign rs = eq.pop_instr[25:21];
assign rt = eq.pop_instr[20:16];
assign rd = eq.pop_instr[15:11];
assign fn = eq.pop_instr[5:0];
assign simm = {{16{eq.pop_instr[15]}}, eq.pop_instr[15:0]};

// register 0 reads zero
assign rs_val = (rs == '0) ? '0 : regs[rs];
assign rt_val = (rt == '0) ? '0 : regs[rt];

// consume only while not holding a store
assign fire = (state == EX_RUN) && eq.pop_valid;
assign eq.pop = fire;

// decode and ALU
always_comb
begin
	wr_en = 1'b0;
	wr_reg = rd;
	wr_val = '0;
	taken = 1'b0;
	is_sw = 1'b0;
	case (op)
	OP_SPECIAL:
	begin
		wr_en = 1'b1;
		case (fn)
		FN_ADDU: wr_val = rs_val + rt_val;
		FN_SUBU: wr_val = rs_val - rt_val;
		FN_AND:  wr_val = rs_val & rt_val;
		FN_OR:   wr_val = rs_val | rt_val;
		FN_XOR:  wr_val = rs_val ^ rt_val;
		// unknown function is a nop
		default: wr_en = 1'b0;
		endcase
	end
	OP_ADDIU:
	begin
		wr_en = 1'b1;
		wr_reg = rt;
		wr_val = rs_val + simm;
	end
	OP_BEQ: taken = (rs_val == rt_val);
	OP_BNE: taken = (rs_val != rt_val);
	OP_SW:  is_sw = 1'b1;
	default: wr_en = 1'b0;
	endcase
end

// no delay slot, target relative to the next word
assign eq.flush = fire && taken;
assign eq.redirect_pc = eq.pop_pc + INSTR_SIZE + {simm[29:0], 2'b00};

// write back at the pop edge
always_ff @(posedge clk)
begin
	if (fire && wr_en && wr_reg != '0)
		regs[wr_reg] <= wr_val;
end

// store FSM
always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
		state <= EX_RUN;
	else if (state == EX_RUN)
	begin
		if (fire && is_sw)
			state <= EX_STORE;
	end
	else if (i_DRdy)
		state <= EX_RUN;
end

// address and data latched when the store pops
always_ff @(posedge clk)
begin
	if (fire && is_sw)
	begin
		st_addr <= rs_val + simm;
		st_data <= rt_val;
	end
end

// data port, word writes only
assign o_DCmd = (state == EX_STORE);
assign o_DRnW = 1'b0;
assign o_DBen = 4'hf;
assign o_DAddr = st_addr;
assign o_DData = st_data;

endmodule

// ==== instr_queue.sv ====
/*
 * Instruction queue
 * circular buffer of instruction and PC pairs,
 * oldest entry shown combinationally, flush empties it
 */

`timescale 1ns/1ps

module instr_queue import cpu_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic   clk,
	input  logic   nrst,
	instr_if.queue q
);

localparam int PTR_W = $clog2(QUEUE_DEPTH);

// storage
word_t instr_mem [QUEUE_DEPTH];
addr_t pc_mem [QUEUE_DEPTH];

// pointers wrap on their own, depth is a power of two
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [PTR_W:0]   count;

logic do_push;
logic do_pop;

assign q.full = (count == (PTR_W+1)'(QUEUE_DEPTH));
assign q.pop_valid = (count != '0);
assign q.pop_instr = instr_mem[rd_ptr];
assign q.pop_pc = pc_mem[rd_ptr];

assign do_push = q.push && !q.full;
assign do_pop = q.pop && q.pop_valid;

// pointers and occupancy
always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end
	else if (q.flush)
	begin
		// flush wins over a push in the same cycle
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end
	else
	begin
		if (do_push)
			wr_ptr <= wr_ptr + 1'b1;
		if (do_pop)
			rd_ptr <= rd_ptr + 1'b1;
		case ({do_push, do_pop})
		2'b10: count <= count + 1'b1;
		2'b01: count <= count - 1'b1;
		default: count <= count;
		endcase
	end
end

// entry write
always_ff @(posedge clk)
begin
	if (do_push && !q.flush)
	begin
		instr_mem[wr_ptr] <= q.push_instr;
		pc_mem[wr_ptr] <= q.push_pc;
	end
end

endmodule

// ==== ifu.sv ====
/*
 * Instruction fetch unit
 * sequences the fetch PC, issues one read at a time on the
 * instruction port and pushes returned words into the queue
 */

`timescale 1ns/1ps

module ifu import cpu_pkg::*; #(
	parameter addr_t RESET_ADDR = '0
) (
	input  logic       clk,
	input  logic       nrst,
	input  word_t      i_IData,
	input  logic       i_IRdy,
	output addr_t      o_IAddr,
	output logic       o_IRdC,
	instr_if.fetch     fq
);

ifu_state_t state;
// address of current or next request
addr_t pc;
// target saved from a flush during a request
addr_t redir_pc;
// word in flight belongs to a flushed path
logic drop;

// request held stable for the whole bus cycle
assign o_IAddr = pc;
assign o_IRdC = (state == IF_WAIT);

// push in the ready cycle, unless already flushed
assign fq.push = (state == IF_WAIT) && i_IRdy && !drop;
assign fq.push_instr = i_IData;
assign fq.push_pc = pc;

// fetch FSM and PC
always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
	begin
		state <= IF_IDLE;
		pc <= RESET_ADDR;
		drop <= 1'b0;
	end
	else
	begin
		case (state)
		IF_IDLE:
		begin
			// nothing outstanding, take the new target now
			if (fq.flush)
				pc <= fq.redirect_pc;
			else if (!fq.full)
				state <= IF_WAIT;
		end
		IF_WAIT:
		begin
			if (i_IRdy)
			begin
				state <= IF_IDLE;
				drop <= 1'b0;
				// flush this cycle also discards the word in the queue
				if (fq.flush)
					pc <= fq.redirect_pc;
				else if (drop)
					pc <= redir_pc;
				else
					pc <= pc + INSTR_SIZE;
			end
			else if (fq.flush)
				drop <= 1'b1;
		end
		default:
			state <= IF_IDLE;
		endcase
	end
end

// redirect target, only meaningful while drop is set
always_ff @(posedge clk)
begin
	if (fq.flush)
		redir_pc <= fq.redirect_pc;
end

endmodule

// ==== instr_if.sv ====
/*
 * Instruction stream interface
 * fetch unit pushes tagged words into the queue,
 * execute unit pops them and may flush and redirect fetch
 */

`timescale 1ns/1ps

interface instr_if import cpu_pkg::*; ();
	// push side
	logic  push;
	word_t push_instr;
	addr_t push_pc;
	logic  full;
	// pop side, oldest entry
	logic  pop;
	logic  pop_valid;
	word_t pop_instr;
	addr_t pop_pc;
	// taken branch
	logic  flush;
	addr_t redirect_pc;

	modport fetch (output push, push_instr, push_pc, input full, flush, redirect_pc);
	modport queue (input push, push_instr, push_pc, pop, flush,
		output full, pop_valid, pop_instr, pop_pc);
	modport exec (output pop, flush, redirect_pc, input pop_valid, pop_instr, pop_pc);
endinterface

// ==== cpu_pkg.sv ====
/*
 * CPU shared definitions
 * width types, MIPS opcode and function encodings,
 * and the state encodings of the fetch and execute FSMs
 */

package cpu_pkg;

	// byte address
	typedef logic [31:0] addr_t;
	// instruction or data word
	typedef logic [31:0] word_t;
	// register number
	typedef logic [4:0] regno_t;

	// program counter step
	localparam addr_t INSTR_SIZE = 32'd4;

	// primary opcodes, bits 31:26
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// function field of special ops, bits 5:0
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;

	// fetch FSM
	typedef enum logic {
		IF_IDLE,
		IF_WAIT
	} ifu_state_t;

	// execute FSM
	typedef enum logic {
		EX_RUN,
		EX_STORE
	} ex_state_t;

endpackage
